//--- design/eth_defs_pkg.sv
package eth_defs_pkg;

	// 48-bit station address as sent on the wire.
	typedef logic [47:0] mac_addr_t;

	// IPv4 address.
	typedef logic [31:0] ip_addr_t;

	// One byte of the MAC client stream.
	typedef logic [7:0] eth_byte_t;

	// EtherType field of the Ethernet header.
	typedef logic [15:0] ethertype_t;

	// Address resolution protocol.
	localparam ethertype_t ETHERTYPE_ARP = 16'h0806;

endpackage

//--- design/arp_defs_pkg.sv
package arp_defs_pkg;

	// ARP over Ethernet and IPv4 has a fixed 28-byte header.
	localparam int ARP_HEAD_LEN = 28;

	// Whole header in wire order, first byte in the top bits.
	typedef logic [ARP_HEAD_LEN*8-1:0] arp_head_t;

	typedef logic [15:0] arp_oper_t;

	localparam arp_oper_t ARP_OP_REQUEST = 16'd1;
	localparam arp_oper_t ARP_OP_REPLY = 16'd2;

	// Fixed fields of an Ethernet/IPv4 header.
	localparam logic [15:0] ARP_HTYPE_ETH = 16'h0001;
	localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
	localparam logic [7:0] ARP_HLEN = 8'd6;
	localparam logic [7:0] ARP_PLEN = 8'd4;

	// Bit positions of the fields read back from a received header.
	localparam int ARP_OPER_LSB = 160;
	localparam int ARP_SHA_LSB = 112;
	localparam int ARP_SPA_LSB = 80;
	localparam int ARP_TPA_LSB = 0;

	// Index of a byte inside the header.
	typedef logic [4:0] byte_count_t;

	localparam byte_count_t ARP_LAST_BYTE = byte_count_t'(ARP_HEAD_LEN - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_HEAD,
		RX_PAYLOAD,
		RX_TAIL
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_HEAD,
		TX_TAIL
	} tx_state_t;

endpackage

//--- design/arp_rx_parser.sv
module arp_rx_parser import eth_defs_pkg::*, arp_defs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rx_new_frame_head,
	input ethertype_t rx_ethertype,
	input logic rx_dven,
	input eth_byte_t rx_data,
	input logic rx_err,
	input ip_addr_t local_ip,
	output logic reply_due,
	output mac_addr_t req_sha,
	output ip_addr_t req_spa
);

	logic frame_head_r;
	ethertype_t ethertype_r;
	logic dven_r;
	eth_byte_t data_r;
	logic err_r;

	rx_state_t state;
	rx_state_t next_state;
	byte_count_t count;
	arp_head_t head;
	logic err_seen;
	logic arp_match;
	arp_oper_t oper;
	ip_addr_t tpa;

	// Input register stage on the MAC stream.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			frame_head_r <= 1'b0;
			dven_r <= 1'b0;
			err_r <= 1'b0;
		end else begin
			frame_head_r <= rx_new_frame_head;
			dven_r <= rx_dven;
			err_r <= rx_err;
		end
	end

	always_ff @(posedge clk) begin
		ethertype_r <= rx_ethertype;
		data_r <= rx_data;
	end

	assign arp_match = frame_head_r && (ethertype_r == ETHERTYPE_ARP);

	always_comb begin
		next_state = state;
		case (state)
			RX_IDLE: begin
				if (arp_match)
					next_state = RX_HEAD;
			end
			RX_HEAD: begin
				// A frame that ends inside the header is dropped.
				if (dven_r && count == ARP_LAST_BYTE)
					next_state = RX_PAYLOAD;
				else if (!dven_r && count != '0)
					next_state = RX_IDLE;
			end
			RX_PAYLOAD: begin
				if (!dven_r)
					next_state = RX_TAIL;
			end
			RX_TAIL: begin
				// Back-to-back frames may start right here.
				next_state = arp_match ? RX_HEAD : RX_IDLE;
			end
			default: next_state = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			count <= '0;
			err_seen <= 1'b0;
		end else begin
			state <= next_state;
			if (state != RX_HEAD)
				count <= '0;
			else if (dven_r)
				count <= count + 1'b1;
			// Error flag sticks from the first header byte to the frame end.
			if (next_state == RX_HEAD && state != RX_HEAD)
				err_seen <= 1'b0;
			else if (dven_r && (state == RX_HEAD || state == RX_PAYLOAD))
				err_seen <= err_seen | err_r;
		end
	end

	// Header shift register with the oldest byte on top.
	always_ff @(posedge clk) begin
		if (state == RX_HEAD && dven_r)
			head <= {head[$bits(arp_head_t)-9:0], data_r};
	end

	assign oper = head[ARP_OPER_LSB +: $bits(arp_oper_t)];
	assign tpa = head[ARP_TPA_LSB +: $bits(ip_addr_t)];
	assign req_sha = head[ARP_SHA_LSB +: $bits(mac_addr_t)];
	assign req_spa = head[ARP_SPA_LSB +: $bits(ip_addr_t)];

	// Verdict at the frame end.
	assign reply_due = (state == RX_TAIL) && !err_seen &&
		(oper == ARP_OP_REQUEST) && (tpa == local_ip);

endmodule

//--- design/arp_reply_holder.sv
module arp_reply_holder import eth_defs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic reply_due,
	input mac_addr_t req_sha,
	input ip_addr_t req_spa,
	input logic tx_ack,
	input logic busy,
	output logic tx_request,
	output logic start,
	output mac_addr_t tha,
	output ip_addr_t tpa
);

	logic accept;

	// One reply in flight at most.
	// Later verdicts are dropped until the serializer is free again.
	assign accept = reply_due && !tx_request && !busy;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_request <= 1'b0;
			start <= 1'b0;
		end else begin
			if (accept)
				tx_request <= 1'b1;
			else if (tx_ack)
				tx_request <= 1'b0;
			// MAC has granted the transmit slot.
			start <= tx_ack;
		end
	end

	// Requester becomes the target of the reply.
	always_ff @(posedge clk) begin
		if (accept) begin
			tha <= req_sha;
			tpa <= req_spa;
		end
	end

endmodule

//--- design/arp_tx_serializer.sv
module arp_tx_serializer import eth_defs_pkg::*, arp_defs_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input mac_addr_t local_mac,
	input ip_addr_t local_ip,
	input mac_addr_t tha,
	input ip_addr_t tpa,
	output logic busy,
	output logic tx_dven,
	output eth_byte_t tx_data,
	output logic tx_err,
	output mac_addr_t tx_dmac,
	output mac_addr_t tx_smac,
	output ethertype_t tx_ethertype
);

	tx_state_t state;
	tx_state_t next_state;
	byte_count_t count;
	arp_head_t reply_head;
	arp_head_t shift;

	// Reply header with the local station as sender.
	assign reply_head = {
		ARP_HTYPE_ETH,
		ARP_PTYPE_IPV4,
		ARP_HLEN,
		ARP_PLEN,
		ARP_OP_REPLY,
		local_mac,
		local_ip,
		tha,
		tpa
	};

	always_comb begin
		next_state = state;
		case (state)
			TX_IDLE: begin
				if (start)
					next_state = TX_START;
			end
			TX_START: next_state = TX_HEAD;
			TX_HEAD: begin
				if (count == ARP_LAST_BYTE)
					next_state = TX_TAIL;
			end
			TX_TAIL: next_state = TX_IDLE;
			default: next_state = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			count <= '0;
			tx_dven <= 1'b0;
		end else begin
			state <= next_state;
			count <= (state == TX_HEAD) ? count + 1'b1 : '0;
			// Valid exactly while the FSM sits in TX_HEAD.
			tx_dven <= (next_state == TX_HEAD);
		end
	end

	always_ff @(posedge clk) begin
		case (next_state)
			TX_START: begin
				shift <= reply_head;
				tx_dmac <= tha;
				tx_smac <= local_mac;
			end
			TX_HEAD: begin
				tx_data <= shift[$bits(arp_head_t)-1 -: 8];
				shift <= shift << 8;
			end
			TX_TAIL: tx_data <= '0;
			default: ;
		endcase
	end

	// Covers the start cycle too, so the holder never sees a gap.
	assign busy = start || (state != TX_IDLE);

	assign tx_err = 1'b0;
	assign tx_ethertype = ETHERTYPE_ARP;

endmodule

//--- design/arp_responder.sv
module arp_responder import eth_defs_pkg::*; (
	input logic clk,
	input logic reset,
	input mac_addr_t local_mac,
	input ip_addr_t local_ip,
	input logic rx_new_frame_head,
	input ethertype_t rx_ethertype,
	input logic rx_dven,
	input eth_byte_t rx_data,
	input logic rx_err,
	input logic tx_ack,
	output logic tx_request,
	output logic tx_dven,
	output eth_byte_t tx_data,
	output logic tx_err,
	output mac_addr_t tx_dmac,
	output mac_addr_t tx_smac,
	output ethertype_t tx_ethertype
);

	logic reply_due;
	mac_addr_t req_sha;
	ip_addr_t req_spa;
	logic start;
	logic busy;
	mac_addr_t tha;
	ip_addr_t tpa;

	// Receive side.
	arp_rx_parser u_rx_parser (
		.clk(clk),
		.reset(reset),
		.rx_new_frame_head(rx_new_frame_head),
		.rx_ethertype(rx_ethertype),
		.rx_dven(rx_dven),
		.rx_data(rx_data),
		.rx_err(rx_err),
		.local_ip(local_ip),
		.reply_due(reply_due),
		.req_sha(req_sha),
		.req_spa(req_spa)
	);

	// Handshake with the MAC.
	arp_reply_holder u_reply_holder (
		.clk(clk),
		.reset(reset),
		.reply_due(reply_due),
		.req_sha(req_sha),
		.req_spa(req_spa),
		.tx_ack(tx_ack),
		.busy(busy),
		.tx_request(tx_request),
		.start(start),
		.tha(tha),
		.tpa(tpa)
	);

	// Transmit side.
	arp_tx_serializer u_tx_serializer (
		.clk(clk),
		.reset(reset),
		.start(start),
		.local_mac(local_mac),
		.local_ip(local_ip),
		.tha(tha),
		.tpa(tpa),
		.busy(busy),
		.tx_dven(tx_dven),
		.tx_data(tx_data),
		.tx_err(tx_err),
		.tx_dmac(tx_dmac),
		.tx_smac(tx_smac),
		.tx_ethertype(tx_ethertype)
	);

endmodule

//--- verification/tb_arp_frames.svh
`ifndef TB_ARP_FRAMES_SVH
`define TB_ARP_FRAMES_SVH

// One test frame and the verdict it should get.
typedef struct packed {
	ethertype_t ethertype;
	arp_oper_t oper;
	mac_addr_t sha;
	ip_addr_t spa;
	ip_addr_t tpa;
	int pad_len;
	int err_at;
	logic reply;
} frame_row_t;

localparam int FRAME_COUNT = 9;
localparam int NO_ERR = -1;

frame_row_t frame_table [FRAME_COUNT];
string frame_name [FRAME_COUNT];

task automatic set_row(input int idx, input string name, input frame_row_t row);
	frame_table[idx] = row;
	frame_name[idx] = name;
endtask

// Ignored frames come first, so the outputs stay quiet until a real request.
// The error index counts bytes from the first header byte.
task automatic load_frame_table();
	set_row(0, "non-arp ethertype", '{16'h0800, ARP_OP_REQUEST,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, LOCAL_IP, 18, NO_ERR, 1'b0});
	set_row(1, "arp reply operation", '{ETHERTYPE_ARP, ARP_OP_REPLY,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, LOCAL_IP, 18, NO_ERR, 1'b0});
	set_row(2, "wrong target ip", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, 32'hc0a8_0a15, 18, NO_ERR, 1'b0});
	set_row(3, "error in header", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, LOCAL_IP, 18, 9, 1'b0});
	set_row(4, "error in padding", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, LOCAL_IP, 18, 37, 1'b0});
	set_row(5, "request, 18 pad bytes", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h00_11_22_33_44_55, 32'hc0a8_0a01, LOCAL_IP, 18, NO_ERR, 1'b1});
	set_row(6, "request, no padding", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h00_0c_29_aa_bb_01, 32'hc0a8_0a02, LOCAL_IP, 0, NO_ERR, 1'b1});
	set_row(7, "request, second sender", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h3c_97_0e_12_34_56, 32'hc0a8_0a63, LOCAL_IP, 18, NO_ERR, 1'b1});
	set_row(8, "request, third sender", '{ETHERTYPE_ARP, ARP_OP_REQUEST,
		48'h88_a4_c2_00_7f_10, 32'hc0a8_0afe, LOCAL_IP, 0, NO_ERR, 1'b1});
endtask

`endif

//--- verification/tb_arp_responder.sv
module tb_arp_responder import eth_defs_pkg::*, arp_defs_pkg::*; ();

	localparam mac_addr_t LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
	localparam ip_addr_t LOCAL_IP = 32'hc0a8_0a14;
	localparam int REQ_TIMEOUT = 200;
	localparam int TX_TIMEOUT = 40;

	logic clk;
	logic reset;
	logic rx_new_frame_head;
	ethertype_t rx_ethertype;
	logic rx_dven;
	eth_byte_t rx_data;
	logic rx_err;
	logic tx_ack;
	logic tx_request;
	logic tx_dven;
	eth_byte_t tx_data;
	logic tx_err;
	mac_addr_t tx_dmac;
	mac_addr_t tx_smac;
	ethertype_t tx_ethertype;

	integer seed;
	int error_count;
	int pass_rows;
	int fail_rows;
	eth_byte_t req_bytes [ARP_HEAD_LEN];
	eth_byte_t exp_bytes [ARP_HEAD_LEN];

	`include "tb_arp_frames.svh"

	arp_responder dut (
		.clk(clk),
		.reset(reset),
		.local_mac(LOCAL_MAC),
		.local_ip(LOCAL_IP),
		.rx_new_frame_head(rx_new_frame_head),
		.rx_ethertype(rx_ethertype),
		.rx_dven(rx_dven),
		.rx_data(rx_data),
		.rx_err(rx_err),
		.tx_ack(tx_ack),
		.tx_request(tx_request),
		.tx_dven(tx_dven),
		.tx_data(tx_data),
		.tx_err(tx_err),
		.tx_dmac(tx_dmac),
		.tx_smac(tx_smac),
		.tx_ethertype(tx_ethertype)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error at %0t: %s expected %0h got %0h", $time, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t: no %s arrived", $time, what);
		error_count++;
	endtask

	// Inputs change and outputs are read just after the rising edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Request header in wire order with an unknown target hardware address.
	task automatic build_request(input frame_row_t row);
		arp_head_t head;
		head = {16'h0001, 16'h0800, 8'd6, 8'd4, row.oper, row.sha, row.spa, 48'h0, row.tpa};
		for (int i = 0; i < ARP_HEAD_LEN; i++)
			req_bytes[i] = head[$bits(arp_head_t) - 1 - 8*i -: 8];
	endtask

	// Reply answers the requester with our own addresses as sender.
	task automatic build_reply(input frame_row_t row);
		arp_head_t head;
		head = {16'h0001, 16'h0800, 8'd6, 8'd4, 16'd2, LOCAL_MAC, LOCAL_IP, row.sha, row.spa};
		for (int i = 0; i < ARP_HEAD_LEN; i++)
			exp_bytes[i] = head[$bits(arp_head_t) - 1 - 8*i -: 8];
	endtask

	task automatic drive_frame(input frame_row_t row);
		int total;
		total = ARP_HEAD_LEN + row.pad_len;
		build_request(row);
		next_cycle();
		rx_new_frame_head = 1'b1;
		rx_ethertype = row.ethertype;
		for (int i = 0; i < total; i++) begin
			next_cycle();
			check_value("tx_request during frame", 0, tx_request);
			check_value("tx_dven during frame", 0, tx_dven);
			rx_new_frame_head = 1'b0;
			rx_dven = 1'b1;
			rx_data = (i < ARP_HEAD_LEN) ? req_bytes[i] : (eth_byte_t'(i) ^ 8'h5a);
			rx_err = (i == row.err_at);
		end
		// First low rx_dven ends the frame.
		next_cycle();
		rx_dven = 1'b0;
		rx_data = '0;
		rx_err = 1'b0;
	endtask

	task automatic wait_request(output logic seen);
		int waited;
		waited = 0;
		while (!tx_request && waited < REQ_TIMEOUT) begin
			check_value("tx_dven without request", 0, tx_dven);
			next_cycle();
			waited++;
		end
		seen = tx_request;
	endtask

	task automatic collect_reply(input frame_row_t row);
		int delay;
		int gap;
		int n;
		build_reply(row);
		delay = $random(seed) & 7;
		repeat (delay) begin
			next_cycle();
			check_value("tx_request before ack", 1, tx_request);
		end
		tx_ack = 1'b1;
		next_cycle();
		tx_ack = 1'b0;
		check_value("tx_request after ack", 0, tx_request);
		gap = 0;
		while (!tx_dven && gap < TX_TIMEOUT) begin
			next_cycle();
			gap++;
		end
		if (!tx_dven) begin
			report_timeout("reply bytes after tx_ack");
			return;
		end
		check_value("cycles from ack to tx_dven", 2, gap);
		check_value("tx_dmac", row.sha, tx_dmac);
		check_value("tx_smac", LOCAL_MAC, tx_smac);
		check_value("tx_ethertype", 16'h0806, tx_ethertype);
		n = 0;
		while (tx_dven && n < TX_TIMEOUT) begin
			if (n < ARP_HEAD_LEN)
				check_value($sformatf("reply byte %0d", n), exp_bytes[n], tx_data);
			check_value("tx_err", 0, tx_err);
			n++;
			next_cycle();
		end
		if (tx_dven)
			report_timeout("end of the reply stream");
		check_value("reply length", ARP_HEAD_LEN, n);
	endtask

	initial begin
		int errors_before;
		logic seen;
		seed = 32'h3bf801ce;
		error_count = 0;
		pass_rows = 0;
		fail_rows = 0;
		clk = 1'b0;
		reset = 1'b1;
		rx_new_frame_head = 1'b0;
		rx_ethertype = '0;
		rx_dven = 1'b0;
		rx_data = '0;
		rx_err = 1'b0;
		tx_ack = 1'b0;
		load_frame_table();
		repeat (8) begin
			next_cycle();
			check_value("tx_request in reset", 0, tx_request);
			check_value("tx_dven in reset", 0, tx_dven);
		end
		reset = 1'b0;
		for (int r = 0; r < FRAME_COUNT; r++) begin
			errors_before = error_count;
			drive_frame(frame_table[r]);
			wait_request(seen);
			if (frame_table[r].reply) begin
				if (seen)
					collect_reply(frame_table[r]);
				else
					report_timeout("tx_request for a matching request");
			end else begin
				check_value("tx_request for an ignored frame", 0, seen);
			end
			repeat (4) next_cycle();
			if (error_count == errors_before) begin
				pass_rows++;
				$display("row %0d %s: ok", r, frame_name[r]);
			end else begin
				fail_rows++;
				$display("row %0d %s: failed", r, frame_name[r]);
			end
		end
		$display("rows passed %0d, failed %0d, errors %0d", pass_rows, fail_rows, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+verification
design/eth_defs_pkg.sv
design/arp_defs_pkg.sv
design/arp_rx_parser.sv
design/arp_reply_holder.sv
design/arp_tx_serializer.sv
design/arp_responder.sv
verification/tb_arp_responder.sv
